// File: Bender.yml
package:
  name: x86_gpr

export_include_dirs:
  - src

sources:
  - src/gpr_pkg.sv
  - src/gpr_if.sv
  - src/uop_issue.sv
  - src/register_file.sv
  - src/alu_writeback.sv
  - src/x86_gpr_top.sv
  - target: test
    files:
      - testbench/tb_x86_gpr.sv

// File: filelist.f
+incdir+src
src/gpr_pkg.sv
src/gpr_if.sv
src/uop_issue.sv
src/register_file.sv
src/alu_writeback.sv
src/x86_gpr_top.sv
testbench/tb_x86_gpr.sv

// File: src/alu_writeback.sv
/*
 * ALU and writeback
 * computes the result of the issued uop at its operand size and
 * drives the writeback bus, including the string-move pointer step
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

module alu_writeback import gpr_pkg::*; (
    input  logic                       iss_valid,
    input  uop_op_e                    iss_op,
    input  opsize_e                    iss_size,
    input  gpr_e                       iss_dst,
    input  logic [`GPR_DATA_WIDTH-1:0] iss_imm,

    input  logic [`GPR_DATA_WIDTH-1:0] op_1_value,
    input  logic [`GPR_DATA_WIDTH-1:0] op_2_value,

    // full-width esi/edi for the pointer step
    gpr_read_if.issue                  ptr_rd,

    gpr_wb_if.exec                     wb,
    output logic                       retire
);

    logic [`GPR_DATA_WIDTH-1:0] alu_raw;
    logic [`GPR_DATA_WIDTH-1:0] alu_result;
    logic [`GPR_DATA_WIDTH-1:0] ptr_step;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------

    // operands are already zero-extended to the uop size
    always_comb begin
        case (iss_op)
            op_mov:     alu_raw = op_2_value;
            op_mov_imm: alu_raw = iss_imm;
            op_add:     alu_raw = op_1_value + op_2_value;
            op_sub:     alu_raw = op_1_value - op_2_value;
            op_and:     alu_raw = op_1_value & op_2_value;
            op_or:      alu_raw = op_1_value | op_2_value;
            op_xor:     alu_raw = op_1_value ^ op_2_value;
            default:    alu_raw = '0;
        endcase
    end

    // truncate so add and sub wrap at the operand size
    always_comb begin
        alu_result = '0;
        case (iss_size)
            size_16: alu_result[15:0] = alu_raw[15:0];
            size_8:  alu_result[7:0]  = alu_raw[7:0];
            default: alu_result = alu_raw;
        endcase
    end

    // ----------------------------------------------------------
    // string move pointer step
    // ----------------------------------------------------------

    assign ptr_rd.op_1      = esi;
    assign ptr_rd.op_2      = edi;
    assign ptr_rd.read_size = size_32;

    always_comb begin
        case (iss_size)
            size_16: ptr_step = `GPR_DATA_WIDTH'd2;
            size_8:  ptr_step = `GPR_DATA_WIDTH'd1;
            default: ptr_step = `GPR_DATA_WIDTH'd4;
        endcase
    end

    // ----------------------------------------------------------
    // writeback
    // ----------------------------------------------------------

    assign wb.writeback_en   = iss_valid && (iss_op != op_movs);
    assign wb.writeback_reg  = iss_dst;
    assign wb.writeback_size = iss_size;
    assign wb.writeback_data = alu_result;

    assign wb.esi_en   = iss_valid && (iss_op == op_movs);
    assign wb.esi_data = ptr_rd.op_1_value + ptr_step;
    assign wb.edi_en   = iss_valid && (iss_op == op_movs);
    assign wb.edi_data = ptr_rd.op_2_value + ptr_step;

    // every accepted uop finishes in its issue cycle
    assign retire = iss_valid;

endmodule

// File: src/gpr_if.sv
/*
 * register file interfaces
 * operand read port pair and writeback / pointer load bus
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

// two operand reads at a common size, values come back combinationally
interface gpr_read_if import gpr_pkg::*; ();
    gpr_e                       op_1;
    gpr_e                       op_2;
    opsize_e                    read_size;
    logic [`GPR_DATA_WIDTH-1:0] op_1_value;
    logic [`GPR_DATA_WIDTH-1:0] op_2_value;

    modport issue (output op_1, output op_2, output read_size,
                   input op_1_value, input op_2_value);
    modport regfile (input op_1, input op_2, input read_size,
                     output op_1_value, output op_2_value);
endinterface

// levels sampled by the register file on the next rising clk edge
interface gpr_wb_if import gpr_pkg::*; ();
    logic                       writeback_en;
    gpr_e                       writeback_reg;
    opsize_e                    writeback_size;
    logic [`GPR_DATA_WIDTH-1:0] writeback_data;
    // direct pointer loads for the string move
    logic                       esi_en;
    logic [`GPR_DATA_WIDTH-1:0] esi_data;
    logic                       edi_en;
    logic [`GPR_DATA_WIDTH-1:0] edi_data;

    modport exec (output writeback_en, output writeback_reg, output writeback_size,
                  output writeback_data, output esi_en, output esi_data,
                  output edi_en, output edi_data);
    modport regfile (input writeback_en, input writeback_reg, input writeback_size,
                     input writeback_data, input esi_en, input esi_data,
                     input edi_en, input edi_data);
endinterface

// File: src/gpr_pkg.sv
/*
 * x86 register slice types
 * register numbers, operand sizes and micro-operation opcodes
 */
`include "gpr_settings.svh"

package gpr_pkg;

    // register numbers, in 8-bit mode 4..7 alias ah, ch, dh, bh
    typedef enum logic [`GPR_SEL_WIDTH-1:0] {
        eax = 3'd0,
        ecx = 3'd1,
        edx = 3'd2,
        ebx = 3'd3,
        esp = 3'd4,
        ebp = 3'd5,
        esi = 3'd6,
        edi = 3'd7
    } gpr_e;

    // operand size, encoding 3 is illegal
    typedef enum logic [1:0] {
        size_32 = 2'd0,
        size_16 = 2'd1,
        size_8  = 2'd2
    } opsize_e;

    typedef enum logic [2:0] {
        op_mov     = 3'd0,
        op_mov_imm = 3'd1,
        op_add     = 3'd2,
        op_sub     = 3'd3,
        op_and     = 3'd4,
        op_or      = 3'd5,
        op_xor     = 3'd6,
        op_movs    = 3'd7
    } uop_op_e;

endpackage

// File: src/gpr_settings.svh
/*
 * x86 general register file sizing
 * register width, register count and register number width
 */
`ifndef GPR_SETTINGS_SVH
`define GPR_SETTINGS_SVH

// width of one general register
`define GPR_DATA_WIDTH 32

// eax through edi
`define GPR_COUNT 8

// bits needed to name one register
`define GPR_SEL_WIDTH 3

`endif

// File: src/register_file.sv
/*
 * x86 general register file
 * eight 32-bit registers with 32/16/8-bit zero-extended reads, high-byte
 * aliasing, merged partial writes, direct esi/edi loads and a debug port
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

module register_file import gpr_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    // operand reads from the issue stage
    gpr_read_if.regfile                rd,
    // full esi/edi reads for the string move
    gpr_read_if.regfile                ptr_rd,

    gpr_wb_if.regfile                  wb,

    input  gpr_e                       dbg_reg,
    input  opsize_e                    dbg_size,
    output logic [`GPR_DATA_WIDTH-1:0] dbg_value
);

    typedef logic [`GPR_COUNT-1:0][`GPR_DATA_WIDTH-1:0] gpr_array_t;

    gpr_array_t                 gpr_q;

    // write side
    logic [`GPR_SEL_WIDTH-1:0]  wb_idx;
    logic [`GPR_DATA_WIDTH-1:0] wb_old;
    logic [`GPR_DATA_WIDTH-1:0] wb_merged;

    // ----------------------------------------------------------
    // size-aware read
    // ----------------------------------------------------------

    // 8-bit numbers 4..7 are ah..bh, i.e. bits 15..8 of eax..ebx
    function automatic logic [`GPR_DATA_WIDTH-1:0] sized_read(
        input gpr_array_t regs,
        input gpr_e       sel,
        input opsize_e    size
    );
        logic [`GPR_DATA_WIDTH-1:0] word;
        logic [`GPR_DATA_WIDTH-1:0] alias_word;
        logic [`GPR_DATA_WIDTH-1:0] value;

        word       = regs[sel];
        alias_word = regs[sel[1:0]];
        value      = '0;
        case (size)
            size_32: value = word;
            size_16: value[15:0] = word[15:0];
            size_8: begin
                if (sel[2]) begin
                    value[7:0] = alias_word[15:8];
                end else begin
                    value[7:0] = word[7:0];
                end
            end
            default: value = '0;
        endcase
        return value;
    endfunction

    assign rd.op_1_value     = sized_read(gpr_q, rd.op_1, rd.read_size);
    assign rd.op_2_value     = sized_read(gpr_q, rd.op_2, rd.read_size);
    assign ptr_rd.op_1_value = sized_read(gpr_q, ptr_rd.op_1, ptr_rd.read_size);
    assign ptr_rd.op_2_value = sized_read(gpr_q, ptr_rd.op_2, ptr_rd.read_size);
    assign dbg_value         = sized_read(gpr_q, dbg_reg, dbg_size);

    // ----------------------------------------------------------
    // writeback merge
    // ----------------------------------------------------------

    // high-byte writes land in register number minus 4
    always_comb begin
        wb_idx = wb.writeback_reg;
        if (wb.writeback_size == size_8 && wb.writeback_reg[2]) begin
            wb_idx = {1'b0, wb.writeback_reg[1:0]};
        end
    end

    assign wb_old = gpr_q[wb_idx];

    // untouched bits keep the old register contents
    always_comb begin
        wb_merged = wb_old;
        case (wb.writeback_size)
            size_32: wb_merged = wb.writeback_data;
            size_16: wb_merged[15:0] = wb.writeback_data[15:0];
            size_8: begin
                if (wb.writeback_reg[2]) begin
                    wb_merged[15:8] = wb.writeback_data[7:0];
                end else begin
                    wb_merged[7:0] = wb.writeback_data[7:0];
                end
            end
            default: wb_merged = wb_old;
        endcase
    end

    // ----------------------------------------------------------
    // register state
    // ----------------------------------------------------------

    // pointer loads come last so they win over a normal writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpr_q <= '0;
        end else begin
            if (wb.writeback_en) begin
                gpr_q[wb_idx] <= wb_merged;
            end
            if (wb.esi_en) begin
                gpr_q[esi] <= wb.esi_data;
            end
            if (wb.edi_en) begin
                gpr_q[edi] <= wb.edi_data;
            end
        end
    end

    a_wb_size_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.writeback_en |-> (wb.writeback_size != 2'd3)
    ) else $error("writeback with illegal operand size");

    // a string move always steps both pointers
    a_ptr_load_paired: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.esi_en == wb.edi_en
    ) else $error("esi and edi loads out of step");

    // normal writeback and pointer load never share a cycle
    a_wb_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wb.writeback_en && wb.esi_en)
    ) else $error("writeback and pointer load in the same cycle");

endmodule

// File: src/uop_issue.sv
/*
 * uop issue stage
 * registers one micro-operation per cycle and drives the operand
 * read selects of the register file
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

module uop_issue import gpr_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       uop_valid,
    input  uop_op_e                    uop_op,
    input  opsize_e                    uop_size,
    input  gpr_e                       uop_dst,
    input  gpr_e                       uop_src,
    input  logic [`GPR_DATA_WIDTH-1:0] uop_imm,

    gpr_read_if.issue                  rd,

    output logic                       iss_valid,
    output uop_op_e                    iss_op,
    output opsize_e                    iss_size,
    output gpr_e                       iss_dst,
    output logic [`GPR_DATA_WIDTH-1:0] iss_imm
);

    // source only feeds the read select, the ALU never sees it
    gpr_e iss_src;

    // ----------------------------------------------------------
    // uop capture
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= uop_valid;
        end
    end

    // payload only moves when a uop arrives
    always_ff @(posedge clk) begin
        if (uop_valid) begin
            iss_op   <= uop_op;
            iss_size <= uop_size;
            iss_dst  <= uop_dst;
            iss_src  <= uop_src;
            iss_imm  <= uop_imm;
        end
    end

    // ----------------------------------------------------------
    // operand read selects
    // ----------------------------------------------------------

    // op_1 is the old destination for two-operand ops
    assign rd.op_1      = iss_dst;
    assign rd.op_2      = iss_src;
    assign rd.read_size = iss_size;

    // the size encoding 3 must never enter the pipe
    a_uop_size_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        uop_valid |-> (uop_size != 2'd3)
    ) else $error("uop issued with illegal operand size");

endmodule

// File: src/x86_gpr_top.sv
/*
 * x86 register execution slice
 * issue stage, register file and ALU/writeback with a debug read port
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

module x86_gpr_top import gpr_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       uop_valid,
    input  uop_op_e                    uop_op,
    input  opsize_e                    uop_size,
    input  gpr_e                       uop_dst,
    input  gpr_e                       uop_src,
    input  logic [`GPR_DATA_WIDTH-1:0] uop_imm,

    input  gpr_e                       dbg_reg,
    input  opsize_e                    dbg_size,
    output logic [`GPR_DATA_WIDTH-1:0] dbg_value,
    output logic                       retire
);

    // issue stage to ALU
    logic                       iss_valid;
    uop_op_e                    iss_op;
    opsize_e                    iss_size;
    gpr_e                       iss_dst;
    logic [`GPR_DATA_WIDTH-1:0] iss_imm;

    gpr_read_if rd_op ();
    gpr_read_if rd_ptr ();
    gpr_wb_if   wb_bus ();

    uop_issue u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop_op    (uop_op),
        .uop_size  (uop_size),
        .uop_dst   (uop_dst),
        .uop_src   (uop_src),
        .uop_imm   (uop_imm),
        .rd        (rd_op.issue),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_size  (iss_size),
        .iss_dst   (iss_dst),
        .iss_imm   (iss_imm)
    );

    register_file u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd_op.regfile),
        .ptr_rd    (rd_ptr.regfile),
        .wb        (wb_bus.regfile),
        .dbg_reg   (dbg_reg),
        .dbg_size  (dbg_size),
        .dbg_value (dbg_value)
    );

    alu_writeback u_alu (
        .iss_valid  (iss_valid),
        .iss_op     (iss_op),
        .iss_size   (iss_size),
        .iss_dst    (iss_dst),
        .iss_imm    (iss_imm),
        .op_1_value (rd_op.op_1_value),
        .op_2_value (rd_op.op_2_value),
        .ptr_rd     (rd_ptr.issue),
        .wb         (wb_bus.exec),
        .retire     (retire)
    );

endmodule

// File: testbench/gpr_vectors.txt
# U op size dst src imm : uop, op 0 mov 1 mov_imm 2 add 3 sub 4 and 5 or 6 xor 7 movs
# C reg size value      : debug read at size 0=32 1=16 2=8, every field in hex
U 1 0 0 0 11223344
U 1 1 0 0 0000aaaa
C 0 0 1122aaaa
U 1 2 0 0 000000bb
U 1 2 4 0 000000cc
C 0 0 1122ccbb
C 0 1 0000ccbb
C 0 2 000000bb
C 4 2 000000cc
U 1 0 3 0 deadbeef
C 7 2 000000be
C 3 2 000000ef
C 4 1 00000000
# alu ops truncated to size
U 1 0 1 0 123456ff
U 1 0 2 0 00000001
U 2 2 1 2 0
C 1 0 12345600
U 3 1 1 2 0
C 1 0 123455ff
U 4 0 1 3 0
C 1 0 122414ef
U 5 2 2 7 0
C 2 0 000000bf
U 6 1 0 3 0
C 0 0 11227254
U 0 0 5 0 0
C 5 0 11227254
U 0 2 6 4 0
C 2 0 000072bf
C 6 2 00000072
# string move steps
U 1 0 6 0 00001000
U 1 0 7 0 00002000
U 7 0 0 0 0
U 7 1 0 0 0
U 7 2 0 0 0
C 6 0 00001007
C 7 0 00002007
C 0 0 11227254
C 2 0 000072bf
C 3 0 deadbeef
C 4 0 00000000

// File: testbench/tb_x86_gpr.sv
/*
 * x86 register slice testbench
 * plays uop and check vectors from a file, then a seeded back-to-back burst
 */
`timescale 1ns/1ps
`include "gpr_settings.svh"

module tb_x86_gpr import gpr_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RETIRE_TIMEOUT = 20;
    localparam int BURST_LEN      = 16;

    logic                       clk;
    logic                       rst_n;
    logic                       uop_valid;
    uop_op_e                    uop_op;
    opsize_e                    uop_size;
    gpr_e                       uop_dst;
    gpr_e                       uop_src;
    logic [`GPR_DATA_WIDTH-1:0] uop_imm;
    gpr_e                       dbg_reg;
    opsize_e                    dbg_size;
    logic [`GPR_DATA_WIDTH-1:0] dbg_value;
    logic                       retire;

    int                         mismatch_count;
    int                         other_count;
    logic                       abort_run;
    integer                     seed;
    // expected register contents for the random burst
    logic [`GPR_DATA_WIDTH-1:0] model_regs [`GPR_COUNT];

    x86_gpr_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop_op    (uop_op),
        .uop_size  (uop_size),
        .uop_dst   (uop_dst),
        .uop_src   (uop_src),
        .uop_imm   (uop_imm),
        .dbg_reg   (dbg_reg),
        .dbg_size  (dbg_size),
        .dbg_value (dbg_value),
        .retire    (retire)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [`GPR_DATA_WIDTH-1:0] actual,
                               input logic [`GPR_DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // ------------------------------------------------------------
    // reference model of the read and merge rules
    // ------------------------------------------------------------

    function automatic logic [`GPR_DATA_WIDTH-1:0] model_read(input int r, input int size);
        logic [`GPR_DATA_WIDTH-1:0] v;
        v = '0;
        if (size == 0) begin
            v = model_regs[r];
        end else if (size == 1) begin
            v[15:0] = model_regs[r][15:0];
        end else if (r >= 4) begin
            v[7:0] = model_regs[r-4][15:8];
        end else begin
            v[7:0] = model_regs[r][7:0];
        end
        return v;
    endfunction

    task automatic model_write(input int r, input int size, input logic [`GPR_DATA_WIDTH-1:0] d);
        if (size == 0) begin
            model_regs[r] = d;
        end else if (size == 1) begin
            model_regs[r][15:0] = d[15:0];
        end else if (r >= 4) begin
            model_regs[r-4][15:8] = d[7:0];
        end else begin
            model_regs[r][7:0] = d[7:0];
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic drive_uop(input int op, input int size, input int dst, input int src,
                             input logic [`GPR_DATA_WIDTH-1:0] imm);
        uop_valid = 1'b1;
        uop_op    = uop_op_e'(op);
        uop_size  = opsize_e'(size);
        uop_dst   = gpr_e'(dst);
        uop_src   = gpr_e'(src);
        uop_imm   = imm;
    endtask

    task automatic await_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retire !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (retire !== 1'b1) begin
            other_count++;
            abort_run = 1'b1;
            $display("timeout: retire never rose after a uop was issued at %0t", $time);
        end
    endtask

    // one uop, then valid drops once it has retired
    task automatic execute_uop(input int op, input int size, input int dst, input int src,
                               input logic [`GPR_DATA_WIDTH-1:0] imm);
        @(negedge clk);
        drive_uop(op, size, dst, src, imm);
        await_retire();
        uop_valid = 1'b0;
    endtask

    task automatic read_back(input int r, input int size,
                             input logic [`GPR_DATA_WIDTH-1:0] expected);
        string name;
        @(negedge clk);
        dbg_reg  = gpr_e'(r);
        dbg_size = opsize_e'(size);
        #(CLK_PERIOD / 4);
        name = $sformatf("dbg_value (reg %0d, size %0d)", r, size);
        check_value(name, dbg_value, expected);
    endtask

    task automatic play_vectors();
        integer                     fd;
        integer                     ch;
        logic [7:0]                 kind;
        logic [`GPR_DATA_WIDTH-1:0] f1, f2, f3, f4, f5;
        fd = $fopen("testbench/gpr_vectors.txt", "r");
        if (fd == 0) begin
            other_count++;
            abort_run = 1'b1;
            $display("could not open the vector file testbench/gpr_vectors.txt");
        end else begin
            while (!abort_run && $fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (kind == "U" && $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5) == 5) begin
                    execute_uop(f1, f2, f3, f4, f5);
                end else if (kind == "C" && $fscanf(fd, "%h %h %h", f1, f2, f3) == 3) begin
                    read_back(f1, f2, f3);
                end else begin
                    other_count++;
                    abort_run = 1'b1;
                    $display("the vector file has a malformed line starting with '%c'", kind);
                end
            end
            $fclose(fd);
        end
    endtask

    // full-width loads of every register, then random mov_imm and add back to back
    task automatic random_burst();
        int                         k;
        int                         op;
        int                         size;
        int                         dst;
        int                         src;
        logic [`GPR_DATA_WIDTH-1:0] imm;
        for (k = 0; k < `GPR_COUNT + BURST_LEN; k++) begin
            op   = 1;
            size = 0;
            dst  = k;
            src  = 0;
            if (k >= `GPR_COUNT) begin
                op   = ($random(seed) & 1) ? 2 : 1;
                size = $unsigned($random(seed)) % 3;
                dst  = $unsigned($random(seed)) % 8;
                src  = $unsigned($random(seed)) % 8;
            end
            imm = $random(seed);
            if (op == 2) begin
                model_write(dst, size, model_read(dst, size) + model_read(src, size));
            end else begin
                model_write(dst, size, imm);
            end
            @(negedge clk);
            if (k > 0) begin
                check_value("retire", retire, 1'b1);
            end
            drive_uop(op, size, dst, src, imm);
        end
        @(negedge clk);
        check_value("retire", retire, 1'b1);
        uop_valid = 1'b0;
        @(negedge clk);
        check_value("retire", retire, 1'b0);
        for (k = 0; k < `GPR_COUNT * 3; k++) begin
            read_back(k / 3, k % 3, model_read(k / 3, k % 3));
        end
    endtask

    initial begin
        seed           = 76;
        mismatch_count = 0;
        other_count    = 0;
        abort_run      = 1'b0;
        rst_n          = 1'b0;
        uop_valid      = 1'b0;
        uop_op         = op_mov;
        uop_size       = size_32;
        uop_dst        = eax;
        uop_src        = eax;
        uop_imm        = '0;
        dbg_reg        = eax;
        dbg_size       = size_32;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_value("retire", retire, 1'b0);
        for (int i = 0; i < `GPR_COUNT * 3; i++) begin
            read_back(i / 3, i % 3, '0);
        end

        play_vectors();
        if (!abort_run) begin
            random_burst();
        end

        $display("errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
